/* include/iso14443a_defs.svh */
// ISO/IEC 14443-2 type A receive path
// widths and code values shared by the packages and the RX logic

`ifndef ISO14443A_DEFS_SVH
`define ISO14443A_DEFS_SVH

// one received data byte
`define RX_BYTE_W        8

// bit position inside a byte, 0..7
`define RX_BITCNT_W      3

// complete bytes per frame, wraps past 63
`define RX_BYTECNT_W     6

// encoding of an illegal pause pattern on the seq_code input
// the other three codes fill the remaining values of the 2-bit field
`define RX_SEQ_BAD_CODE  2'b11

`endif

/* source/rx_frame_pkg.sv */
// frame level types for the type A receive path
// byte payload, leftover bit count and byte count per frame

`include "iso14443a_defs.svh"

package rx_frame_pkg;

    // one data byte, first received bit in bit 0
    typedef logic [`RX_BYTE_W-1:0] rx_byte_t;

    // valid bits in the final byte
    // 0 means the frame ended on a byte boundary
    typedef logic [`RX_BITCNT_W-1:0] rx_bitcnt_t;

    // complete bytes seen in a frame
    typedef logic [`RX_BYTECNT_W-1:0] rx_bytecnt_t;

endpackage

/* source/rx_line_pkg.sv */
// line code types for the type A receive path
// Modified Miller sequences and the sequence decoder FSM states

`include "iso14443a_defs.svh"

package rx_line_pkg;

    // one symbol per bit period, as classified by the pause detector
    typedef enum logic [1:0] {
        SEQ_X   = 2'b00,            // pause in the second half
        SEQ_Y   = 2'b01,            // no pause
        SEQ_Z   = 2'b10,            // pause in the first half
        SEQ_BAD = `RX_SEQ_BAD_CODE  // anything else
    } miller_seq_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_WAIT_IDLE
    } seqdec_state_e;

endpackage

/* source/sequence_decode.sv */
// Modified Miller sequence decoder
// turns one code per bit period into SOC, data bits, EOC and coding errors
// all outputs are registered single-cycle pulses

`timescale 1ns/1ps

module sequence_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     seq_valid,
    input  rx_line_pkg::miller_seq_e seq_code,
    output logic                     soc,
    output logic                     eoc,
    output logic                     data_valid,
    output logic                     data,
    output logic                     error
);
    import rx_line_pkg::*;

    seqdec_state_e state;
    // value of the previous bit, decides how Y and Z are read
    logic          prev_bit;
    // one Y already seen while waiting for the line to go idle
    logic          y_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            prev_bit   <= 1'b0;
            y_count    <= 1'b0;
            soc        <= 1'b0;
            eoc        <= 1'b0;
            data_valid <= 1'b0;
            error      <= 1'b0;
        end else begin
            // pulses drop after one cycle
            soc        <= 1'b0;
            eoc        <= 1'b0;
            data_valid <= 1'b0;
            error      <= 1'b0;

            if (seq_valid) begin
                case (state)
                    ST_IDLE: begin
                        // SOC is a Z, i.e. a logic 0 that is not data
                        if (seq_code == SEQ_Z) begin
                            soc      <= 1'b1;
                            prev_bit <= 1'b0;
                            state    <= ST_DATA;
                        end
                    end

                    ST_DATA: begin
                        case (seq_code)
                            SEQ_X: begin
                                data_valid <= 1'b1;
                                prev_bit   <= 1'b1;
                            end
                            SEQ_Y: begin
                                if (prev_bit) begin
                                    // Y after a 1 is a 0
                                    data_valid <= 1'b1;
                                    prev_bit   <= 1'b0;
                                end else begin
                                    // logic 0 followed by Y marks the end
                                    eoc   <= 1'b1;
                                    state <= ST_IDLE;
                                end
                            end
                            SEQ_Z: begin
                                if (!prev_bit) begin
                                    data_valid <= 1'b1;
                                end else begin
                                    // Z may never follow a 1
                                    error   <= 1'b1;
                                    y_count <= 1'b0;
                                    state   <= ST_WAIT_IDLE;
                                end
                            end
                            default: begin
                                error   <= 1'b1;
                                y_count <= 1'b0;
                                state   <= ST_WAIT_IDLE;
                            end
                        endcase
                    end

                    ST_WAIT_IDLE: begin
                        // two Y in a row means the reader stopped sending
                        if (seq_code == SEQ_Y) begin
                            if (y_count) begin
                                eoc     <= 1'b1;
                                y_count <= 1'b0;
                                state   <= ST_IDLE;
                            end else begin
                                y_count <= 1'b1;
                            end
                        end else begin
                            y_count <= 1'b0;
                        end
                    end

                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // only X carries a 1, every other data bit is 0
    always_ff @(posedge clk) begin
        if (seq_valid) begin
            data <= (seq_code == SEQ_X);
        end
    end

    a_soc_eoc_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(soc && eoc));

    a_no_data_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid |-> state != ST_IDLE);

    // the front end delivers at most one code per bit period
    a_strobe_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        seq_valid |=> !seq_valid);

endmodule

/* source/frame_decode.sv */
// frame level checks on the decoded bit stream
// strips the odd parity bit after each data byte and flags parity errors,
// a missing parity bit, empty frames and upstream coding errors
// last_bit holds the most recent bit received, parity included

`timescale 1ns/1ps

module frame_decode (
    input  logic clk,
    input  logic rst_n,
    input  logic in_soc,
    input  logic in_eoc,
    input  logic in_data_valid,
    input  logic in_data,
    input  logic in_error,
    output logic out_soc,
    output logic out_eoc,
    output logic out_data_valid,
    output logic out_data,
    output logic out_error,
    output logic last_bit
);
    import rx_frame_pkg::*;

    // data bits received in the current byte
    rx_bitcnt_t bit_count;
    // eight data bits done, next bit is parity
    logic       parity_due;
    // running odd parity, starts at 1
    logic       parity_acc;
    // at least one bit arrived since SOC
    logic       data_seen;
    // error already reported for this frame
    logic       error_seen;

    // SOC goes straight through
    assign out_soc = in_soc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_count      <= '0;
            parity_due     <= 1'b0;
            parity_acc     <= 1'b1;
            data_seen      <= 1'b0;
            error_seen     <= 1'b0;
            out_eoc        <= 1'b0;
            out_data_valid <= 1'b0;
            out_error      <= 1'b0;
            last_bit       <= 1'b0;
        end else begin
            out_eoc        <= 1'b0;
            out_data_valid <= 1'b0;
            out_error      <= 1'b0;

            // frame delay timing needs every bit, parity too
            if (in_data_valid) begin
                last_bit <= in_data;
            end

            if (in_soc) begin
                bit_count  <= '0;
                parity_due <= 1'b0;
                parity_acc <= 1'b1;
                data_seen  <= 1'b0;
                error_seen <= 1'b0;
            end

            // EOC is registered so it lines up with an error raised here
            if (in_eoc) begin
                out_eoc <= 1'b1;
                if (!error_seen && (parity_due || !data_seen)) begin
                    out_error  <= 1'b1;
                    error_seen <= 1'b1;
                end
            end

            // after an error nothing more until the next SOC
            if (!error_seen) begin
                if (in_data_valid) begin
                    data_seen <= 1'b1;
                    if (parity_due) begin
                        parity_due <= 1'b0;
                        parity_acc <= 1'b1;
                        if (in_data != parity_acc) begin
                            out_error  <= 1'b1;
                            error_seen <= 1'b1;
                        end
                    end else begin
                        out_data_valid <= 1'b1;
                        parity_acc     <= parity_acc ^ in_data;
                        bit_count      <= bit_count + rx_bitcnt_t'(1);
                        if (bit_count == '1) begin
                            parity_due <= 1'b1;
                        end
                    end
                end

                if (in_error) begin
                    out_error  <= 1'b1;
                    error_seen <= 1'b1;
                end
            end
        end
    end

    // qualified by out_data_valid
    always_ff @(posedge clk) begin
        if (in_data_valid) begin
            out_data <= in_data;
        end
    end

    a_one_error_per_frame: assert property (@(posedge clk) disable iff (!rst_n)
        out_error |=> !out_error until out_soc);

    a_no_data_after_error: assert property (@(posedge clk) disable iff (!rst_n)
        out_error |=> !out_data_valid until out_soc);

endmodule

/* source/byte_assemble.sv */
// packs the checked bit stream into bytes, LSB first
// at EOC gives a frame summary: error flag, byte count and leftover bits
// a trailing partial byte is counted in last_bits but never emitted

`timescale 1ns/1ps

module byte_assemble (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      soc,
    input  logic                      eoc,
    input  logic                      data_valid,
    input  logic                      data,
    input  logic                      error,
    output logic                      byte_valid,
    output rx_frame_pkg::rx_byte_t    byte_data,
    output logic                      frame_end,
    output logic                      frame_error,
    output rx_frame_pkg::rx_bitcnt_t  last_bits,
    output rx_frame_pkg::rx_bytecnt_t byte_count
);
    import rx_frame_pkg::*;

    rx_byte_t    shift_reg;
    rx_byte_t    next_byte;
    // bits collected in the current byte
    rx_bitcnt_t  bit_pos;
    // complete bytes this frame
    rx_bytecnt_t byte_cnt;
    // any error since SOC
    logic        err_sticky;

    // new bit enters at the top, first bit ends up in bit 0
    assign next_byte = {data, shift_reg[$bits(rx_byte_t)-1:1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_pos     <= '0;
            byte_cnt    <= '0;
            err_sticky  <= 1'b0;
            byte_valid  <= 1'b0;
            frame_end   <= 1'b0;
            frame_error <= 1'b0;
            last_bits   <= '0;
            byte_count  <= '0;
        end else begin
            byte_valid <= 1'b0;
            frame_end  <= 1'b0;

            if (soc) begin
                bit_pos    <= '0;
                byte_cnt   <= '0;
                err_sticky <= 1'b0;
            end

            if (error) begin
                err_sticky <= 1'b1;
            end

            if (data_valid) begin
                bit_pos <= bit_pos + rx_bitcnt_t'(1);
                // eighth bit completes a byte
                if (bit_pos == '1) begin
                    byte_valid <= 1'b1;
                    byte_cnt   <= byte_cnt + rx_bytecnt_t'(1);
                end
            end

            // error may arrive together with EOC
            if (eoc) begin
                frame_end   <= 1'b1;
                frame_error <= err_sticky | error;
                last_bits   <= bit_pos;
                byte_count  <= byte_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            shift_reg <= next_byte;
            if (bit_pos == '1) begin
                byte_data <= next_byte;
            end
        end
    end

    // EOC and data are never in the same cycle upstream
    a_byte_or_end: assert property (@(posedge clk) disable iff (!rst_n)
        !(byte_valid && frame_end));

endmodule

/* source/iso14443a_rx.sv */
// ISO/IEC 14443-2 type A receive path, reader to card
// sequence decoder, parity and frame checks, then byte packing

`timescale 1ns/1ps

module iso14443a_rx (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      seq_valid,
    input  rx_line_pkg::miller_seq_e  seq_code,
    output logic                      soc,
    output logic                      byte_valid,
    output rx_frame_pkg::rx_byte_t    byte_data,
    output logic                      frame_end,
    output logic                      frame_error,
    output rx_frame_pkg::rx_bitcnt_t  last_bits,
    output rx_frame_pkg::rx_bytecnt_t byte_count,
    output logic                      last_bit
);

    // sequence decoder to frame checker
    logic seq_soc;
    logic seq_eoc;
    logic seq_data_valid;
    logic seq_data;
    logic seq_error;

    // frame checker to byte packer
    logic fd_eoc;
    logic fd_data_valid;
    logic fd_data;
    logic fd_error;

    sequence_decode u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .seq_valid  (seq_valid),
        .seq_code   (seq_code),
        .soc        (seq_soc),
        .eoc        (seq_eoc),
        .data_valid (seq_data_valid),
        .data       (seq_data),
        .error      (seq_error)
    );

    // fd_soc is combinational, so it is the top-level soc as well
    frame_decode u_frame (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_soc         (seq_soc),
        .in_eoc         (seq_eoc),
        .in_data_valid  (seq_data_valid),
        .in_data        (seq_data),
        .in_error       (seq_error),
        .out_soc        (soc),
        .out_eoc        (fd_eoc),
        .out_data_valid (fd_data_valid),
        .out_data       (fd_data),
        .out_error      (fd_error),
        .last_bit       (last_bit)
    );

    byte_assemble u_bytes (
        .clk         (clk),
        .rst_n       (rst_n),
        .soc         (soc),
        .eoc         (fd_eoc),
        .data_valid  (fd_data_valid),
        .data        (fd_data),
        .error       (fd_error),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_end   (frame_end),
        .frame_error (frame_error),
        .last_bits   (last_bits),
        .byte_count  (byte_count)
    );

endmodule

/* tests/iso14443a_rx_tb.sv */
// testbench for the type A receive path
// encodes frames into Modified Miller codes, predicts the decoded result
// and compares bytes and frame summaries as the DUT reports them

`timescale 1ns/1ps

module iso14443a_rx_tb;
    import rx_line_pkg::*;
    import rx_frame_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        seq_valid;
    miller_seq_e seq_code;
    logic        soc;
    logic        byte_valid;
    rx_byte_t    byte_data;
    logic        frame_end;
    logic        frame_error;
    rx_bitcnt_t  last_bits;
    rx_bytecnt_t byte_count;
    logic        last_bit;

    // frame under test, data and parity bits in sending order
    logic        line_bits[$];
    // bit replaced by an illegal code, -1 for none
    int          bad_pos;
    miller_seq_e bad_code;

    // expected frame result
    rx_byte_t    exp_bytes[$];
    rx_bitcnt_t  exp_last_bits;
    logic        exp_error;
    logic        exp_last_bit;

    rx_byte_t    got_bytes[$];
    int          frames_done = 0;
    int          err_count = 0;
    int          fail_count = 0;
    int          check_count = 0;

    iso14443a_rx uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .seq_valid   (seq_valid),
        .seq_code    (seq_code),
        .soc         (soc),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_end   (frame_end),
        .frame_error (frame_error),
        .last_bits   (last_bits),
        .byte_count  (byte_count),
        .last_bit    (last_bit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected bytes, leftover bits, last bit and error flag of line_bits
    function automatic logic predict_frame();
        rx_byte_t cur;
        int       cnt;
        int       n;
        int       total;
        logic     par_due;
        logic     err;
        logic     b;
        exp_bytes.delete();
        cur = '0;
        cnt = 0;
        par_due = 1'b0;
        err = 1'b0;
        n = (bad_pos >= 0) ? bad_pos : line_bits.size();
        total = n;
        // ending after a 1 costs one Y that decodes as an extra 0
        if (bad_pos < 0 && n > 0 && line_bits[n-1]) begin
            total = n + 1;
        end
        for (int i = 0; i < total; i++) begin
            b = (i < n) ? line_bits[i] : 1'b0;
            exp_last_bit = b;
            if (!err) begin
                if (par_due) begin
                    // byte plus parity must hold an odd number of ones
                    if (b == ^cur) begin
                        err = 1'b1;
                    end
                    par_due = 1'b0;
                end else begin
                    cur[cnt] = b;
                    cnt++;
                    if (cnt == 8) begin
                        exp_bytes.push_back(cur);
                        cnt = 0;
                        par_due = 1'b1;
                    end
                end
            end
        end
        // illegal code, missing parity or no bits at all
        if (bad_pos >= 0 || par_due || total == 0) begin
            err = 1'b1;
        end
        exp_last_bits = rx_bitcnt_t'(cnt);
        return err;
    endfunction

    task automatic clear_frame();
        line_bits.delete();
        bad_pos = -1;
        bad_code = SEQ_BAD;
    endtask

    // 8 data bits LSB first, then odd parity, inverted when flip is set
    task automatic add_byte(input rx_byte_t b, input logic flip);
        for (int i = 0; i < 8; i++) begin
            line_bits.push_back(b[i]);
        end
        line_bits.push_back(~(^b) ^ flip);
    endtask

    // raw data bits with no parity, for short frames
    task automatic add_bits(input rx_byte_t b, input int n);
        for (int i = 0; i < n; i++) begin
            line_bits.push_back(b[i]);
        end
    endtask

    // one strobe after 2 to 5 idle cycles
    task automatic send_code(input miller_seq_e code);
        int gap;
        gap = 2 + int'($urandom % 4);
        repeat (gap) @(posedge clk);
        seq_valid <= 1'b1;
        seq_code  <= code;
        @(posedge clk);
        seq_valid <= 1'b0;
    endtask

    task automatic send_frame();
        logic prev;
        int   i;
        // SOC is a Z, previous bit counts as 0
        send_code(SEQ_Z);
        prev = 1'b0;
        // an illegal code takes the place of one bit, the rest still goes out
        for (i = 0; i < line_bits.size(); i++) begin
            if (i == bad_pos) begin
                send_code(bad_code);
            end else if (line_bits[i]) begin
                send_code(SEQ_X);
            end else if (prev) begin
                send_code(SEQ_Y);
            end else begin
                send_code(SEQ_Z);
            end
            prev = line_bits[i];
        end
        if (bad_pos >= 0) begin
            // two Y let the decoder leave wait-idle
            send_code(SEQ_Y);
            send_code(SEQ_Y);
        end else begin
            // EOC is a Y following a logic 0
            if (prev) begin
                send_code(SEQ_Y);
            end
            send_code(SEQ_Y);
        end
    endtask

    task automatic run_frame(input string name);
        int start;
        int wait_cycles;
        exp_error = predict_frame();
        start = frames_done;
        send_frame();
        wait_cycles = 0;
        while (frames_done == start && wait_cycles < 40) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (frames_done == start) begin
            $display("timeout: frame %s never produced frame_end", name);
            fail_count++;
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic compare_frame();
        int n;
        check_count++;
        assert (got_bytes.size() == exp_bytes.size()) else begin
            $display("ERR %0t byte_valid count got %0d expected %0d",
                     $time, got_bytes.size(), exp_bytes.size());
            err_count++;
        end
        n = (got_bytes.size() < exp_bytes.size()) ? got_bytes.size() : exp_bytes.size();
        for (int i = 0; i < n; i++) begin
            assert (got_bytes[i] == exp_bytes[i]) else begin
                $display("ERR %0t byte_data[%0d] got %02h expected %02h",
                         $time, i, got_bytes[i], exp_bytes[i]);
                err_count++;
            end
        end
        assert (byte_count == rx_bytecnt_t'(exp_bytes.size())) else begin
            $display("ERR %0t byte_count got %0d expected %0d",
                     $time, byte_count, exp_bytes.size());
            err_count++;
        end
        assert (last_bits == exp_last_bits) else begin
            $display("ERR %0t last_bits got %0d expected %0d", $time, last_bits, exp_last_bits);
            err_count++;
        end
        assert (frame_error == exp_error) else begin
            $display("ERR %0t frame_error got %0b expected %0b", $time, frame_error, exp_error);
            err_count++;
        end
        // after a coding error last_bit keeps the bit decoded before it
        assert (last_bit == exp_last_bit) else begin
            $display("ERR %0t last_bit got %0b expected %0b", $time, last_bit, exp_last_bit);
            err_count++;
        end
    endtask

    // collects bytes per frame and checks the summary at frame_end
    always @(posedge clk) begin
        if (rst_n) begin
            if (soc) begin
                got_bytes.delete();
            end
            if (byte_valid) begin
                got_bytes.push_back(byte_data);
            end
            if (frame_end) begin
                compare_frame();
                frames_done++;
            end
        end
    end

    initial begin
        int       nbytes;
        int       nbits;
        rx_byte_t b;
        rst_n     = 1'b0;
        seq_valid = 1'b0;
        seq_code  = SEQ_Y;
        clear_frame();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        void'($urandom(32'h9a71_0c10));

        @(negedge clk);
        assert (!soc && !byte_valid && !frame_end && !last_bit) else begin
            $display("pulse outputs or last_bit not low after reset");
            fail_count++;
        end

        // random valid frames, the closing parity bit kept at 0
        for (int f = 0; f < 6; f++) begin
            nbytes = 1 + int'($urandom % 8);
            clear_frame();
            for (int k = 0; k < nbytes; k++) begin
                b = rx_byte_t'($urandom);
                if (k == nbytes - 1 && ^b == 1'b0) begin
                    b[0] = ~b[0];
                end
                add_byte(b, 1'b0);
            end
            run_frame("random");
        end

        // REQA, 7 bits and no parity
        clear_frame();
        add_bits(8'h26, 7);
        run_frame("reqa");

        // one full byte plus a short tail ending on 0
        for (int f = 0; f < 3; f++) begin
            nbits = 1 + int'($urandom % 7);
            b = rx_byte_t'($urandom);
            b[nbits-1] = 1'b0;
            clear_frame();
            add_byte(rx_byte_t'($urandom), 1'b0);
            add_bits(b, nbits);
            run_frame("short tail");
        end

        // parity flipped in the third byte of five
        clear_frame();
        for (int k = 0; k < 5; k++) begin
            add_byte(rx_byte_t'($urandom), k == 2);
        end
        run_frame("parity");

        // illegal pause pattern in the second byte
        clear_frame();
        add_byte(8'ha5, 1'b0);
        add_byte(8'h0f, 1'b0);
        add_byte(8'h77, 1'b0);
        bad_pos = 13;
        bad_code = SEQ_BAD;
        run_frame("bad code");

        // Z right after a 1, bit 11 is a one of 8'hff
        clear_frame();
        add_byte(8'h3c, 1'b0);
        add_byte(8'hff, 1'b0);
        add_byte(8'h55, 1'b0);
        bad_pos = 12;
        bad_code = SEQ_Z;
        run_frame("z after one");

        // 8 data bits and EOC where the parity bit belongs
        clear_frame();
        add_bits(8'h5a, 8);
        run_frame("no parity");

        // SOC directly followed by EOC
        clear_frame();
        run_frame("empty");

        $display("frames checked %0d, value errors %0d, other failures %0d",
                 check_count, err_count, fail_count);
        if (err_count == 0 && fail_count == 0 && check_count > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
source/rx_frame_pkg.sv
source/rx_line_pkg.sv
source/sequence_decode.sv
source/frame_decode.sv
source/byte_assemble.sv
source/iso14443a_rx.sv
tests/iso14443a_rx_tb.sv
